// ==== rtl/rename_reg_pkg.sv ====
// ========================================
// register-number sizes for the renamer, 32 architectural registers
// mapped onto 64 physical registers, widths follow from the counts
// ========================================
package rename_reg_pkg;

   // ========================================
   // register file sizes
   // ========================================
   localparam int ARCH_REGS = 32;   // architectural registers seen by software
   localparam int PREGS     = 64;   // physical registers in the core

   localparam int ARCH_W = $clog2(ARCH_REGS);
   localparam int PREG_W = $clog2(PREGS);

   // ========================================
   // register number types
   // ========================================

   // an architectural register number as decoded from the instruction
   typedef logic [ARCH_W-1:0] arch_reg_t;

   // a physical register number, the index into the physical register file
   typedef logic [PREG_W-1:0] preg_t;

endpackage

// ==== rtl/rename_msg_pkg.sv ====
// ========================================
// message formats on the renamer boundary, field order is fixed
// and the first field sits in the upper bits of each struct
// ========================================
package rename_msg_pkg;
   import rename_reg_pkg::*;

   // one rename request from the front end, 16 bits
   typedef struct packed {
      arch_reg_t src1;      // first source operand
      arch_reg_t src2;      // second source operand
      arch_reg_t dst;       // destination, ignored unless has_dst is set
      logic      has_dst;   // instruction writes a register
   } rename_req_t;

   // rename result handed to the issue side, 25 bits
   typedef struct packed {
      preg_t src1_preg;     // physical register holding src1
      preg_t src2_preg;     // physical register holding src2
      preg_t dst_preg;      // newly allocated destination register
      preg_t old_preg;      // previous mapping of dst, freed at retire
      logic  has_dst;       // dst_preg and old_preg are meaningful
   } rename_rsp_t;

   // one retiring instruction hands back its old mapping, 6 bits
   typedef struct packed {
      preg_t old_preg;
   } commit_t;

endpackage

// ==== rtl/credit_queue.sv ====
`timescale 1ns/1ps
// ========================================
// sender starts with DEPTH credits and spends one per push, credit
// pulses one cycle after each pop, pushes while full are illegal
// ========================================
module credit_queue #(
   parameter int  DEPTH     = 4,            // entries, also the sender's credit count
   parameter type payload_t = logic [7:0]   // entry type, set per stream
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,        // sender writes one entry
   input  payload_t push_data,
   input  logic     pop,         // consumer takes the head entry
   output logic     q_valid,     // head entry present
   output payload_t q_data,      // head entry
   output logic     credit       // one credit back to the sender
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;   // entries held, 0 to DEPTH
   logic             do_pop;

   // pointer step with wrap, DEPTH need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1))
         return '0;
      return p + 1'b1;
   endfunction

   assign q_valid = (count != '0);
   assign q_data  = mem[rd_ptr];        // head is readable in the same cycle
   assign do_pop  = pop & q_valid;

   // ========================================
   // pointers, occupancy and credit return
   // ========================================
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;   // no credit pulse until the first pop
      end else begin
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_next(rd_ptr);
         count  <= count + CNT_W'(push) - CNT_W'(do_pop);
         credit <= do_pop;   // the freed slot goes back one cycle later
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   // a push into a full queue means the sender ran past its credits
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      push |-> (count != CNT_W'(DEPTH)));

   // the consumer only pops what it saw as valid
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      pop |-> q_valid);

endmodule

// ==== rtl/preg_free_list.sv ====
`timescale 1ns/1ps
// ========================================
// fills itself with registers ARCH_REGS..PREGS-1 after reset, pops
// are illegal while busy is high, busy drops after that many cycles
// ========================================
module preg_free_list import rename_reg_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  push,        // a retired register comes back
   input  preg_t push_preg,
   input  logic  pop,         // rename takes the head register
   output preg_t head_preg,   // next register to allocate
   output logic  empty,
   output logic  busy         // self-fill still running
);
   localparam int FILL_N = PREGS - ARCH_REGS;   // registers free after reset
   localparam int CNT_W  = $clog2(PREGS + 1);

   preg_t            mem [PREGS];
   preg_t            wr_ptr;   // PREGS is a power of two so pointers wrap freely
   preg_t            rd_ptr;
   logic [CNT_W-1:0] count;
   preg_t            fill_cnt; // index of the next register to preload
   logic             wr_en;
   preg_t            wr_data;
   logic             do_pop;

   // the preload owns the write port while busy
   assign wr_en   = busy | push;
   assign wr_data = busy ? preg_t'(ARCH_REGS) + fill_cnt : push_preg;
   assign do_pop  = pop & ~empty & ~busy;

   assign empty     = (count == '0);
   assign head_preg = mem[rd_ptr];   // valid together with empty

   // ========================================
   // self-fill sequence after reset
   // ========================================
   always_ff @(posedge clk) begin
      if (rst) begin
         fill_cnt <= '0;
         busy     <= 1'b1;
      end else if (busy) begin
         fill_cnt <= fill_cnt + 1'b1;
         if (fill_cnt == preg_t'(FILL_N - 1))
            busy <= 1'b0;   // last preload lands on this edge
      end
   end

   // ========================================
   // FIFO pointers and occupancy
   // ========================================
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + CNT_W'(wr_en) - CNT_W'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   // more returns than registers means a register was freed twice
   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      push |-> (count != CNT_W'(PREGS)));

   // rename must wait for both the preload and a free register
   a_pop_legal: assert property (@(posedge clk) disable iff (rst)
      pop |-> (!empty && !busy));

endmodule

// ==== rtl/rename_map_table.sv ====
`timescale 1ns/1ps
// ========================================
// reads are combinational and see the map before this cycle's
// write, reset maps architectural register i to physical i
// ========================================
module rename_map_table import rename_reg_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  arch_reg_t rd_src1,     // first source lookup
   input  arch_reg_t rd_src2,     // second source lookup
   input  arch_reg_t rd_dst,      // destination lookup for the old mapping
   input  logic      wr_en,       // install a new mapping
   input  arch_reg_t wr_arch,
   input  preg_t     wr_preg,
   output preg_t     src1_preg,
   output preg_t     src2_preg,
   output preg_t     old_preg
);
   // current speculative mapping, one entry per architectural register
   preg_t map_q [ARCH_REGS];

   // ========================================
   // read ports
   // ========================================
   assign src1_preg = map_q[rd_src1];
   assign src2_preg = map_q[rd_src2];
   assign old_preg  = map_q[rd_dst];   // the register this dst gives up

   // ========================================
   // write port and identity reset
   // ========================================
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < ARCH_REGS; i++) begin
            map_q[i] <= preg_t'(i);   // registers 0..31 start out as their own copies
         end
      end else if (wr_en) begin
         map_q[wr_arch] <= wr_preg;   // visible to the lookup on the next cycle
      end
   end

endmodule

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps
// ========================================
// one request per cycle, response one cycle later, the consumer
// must always accept a response since there is no back-pressure
// ========================================
module rename_stage import rename_reg_pkg::*, rename_msg_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        q_valid,      // head request present
   input  rename_req_t q_data,
   input  preg_t       fl_head,      // register that would be allocated
   input  logic        fl_empty,
   input  logic        fl_busy,
   input  preg_t       src1_preg,    // map lookups for the head request
   input  preg_t       src2_preg,
   input  preg_t       old_preg,
   output logic        q_pop,
   output logic        fl_pop,
   output arch_reg_t   rd_src1,
   output arch_reg_t   rd_src2,
   output arch_reg_t   rd_dst,
   output logic        map_wr_en,
   output arch_reg_t   map_wr_arch,
   output preg_t       map_wr_preg,
   output logic        rsp_valid,
   output rename_rsp_t rsp
);
   logic take;   // head request is renamed this cycle

   // ========================================
   // accept decision and allocation
   // ========================================

   // a request without a destination needs no free register, but the
   // whole stage waits out the free list preload
   assign take = q_valid & ~fl_busy & (~q_data.has_dst | ~fl_empty);

   assign q_pop  = take;
   assign fl_pop = take & q_data.has_dst;

   assign rd_src1 = q_data.src1;
   assign rd_src2 = q_data.src2;
   assign rd_dst  = q_data.dst;

   // the new mapping lands on the edge where the next request is looked up,
   // so back-to-back dependent requests see it without a bypass
   assign map_wr_en   = fl_pop;
   assign map_wr_arch = q_data.dst;
   assign map_wr_preg = fl_head;

   // ========================================
   // response register
   // ========================================
   always_ff @(posedge clk) begin
      if (rst)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= take;
   end

   always_ff @(posedge clk) begin
      if (take) begin
         rsp.src1_preg <= src1_preg;   // mapping before this request's own write
         rsp.src2_preg <= src2_preg;
         rsp.dst_preg  <= q_data.has_dst ? fl_head : '0;
         rsp.old_preg  <= q_data.has_dst ? old_preg : '0;
         rsp.has_dst   <= q_data.has_dst;
      end
   end

   // a free register is mapped by no architectural register, so a head
   // that matches a current lookup was handed back twice
   a_alloc_unmapped: assert property (@(posedge clk) disable iff (rst)
      fl_pop |-> (fl_head != old_preg) && (fl_head != src1_preg) && (fl_head != src2_preg));

endmodule

// ==== rtl/renamer_top.sv ====
`timescale 1ns/1ps
// ========================================
// both inbound streams are credit based, senders start with
// REQ_DEPTH and CMT_DEPTH credits, responses are never stalled
// ========================================
module renamer_top import rename_reg_pkg::*, rename_msg_pkg::*; #(
   parameter int REQ_DEPTH = 4,   // request queue depth and front end credits
   parameter int CMT_DEPTH = 4    // commit queue depth and committer credits
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        req_valid,
   input  rename_req_t req,
   output logic        req_credit,
   input  logic        cmt_valid,
   input  commit_t     cmt,
   output logic        cmt_credit,
   output logic        rsp_valid,
   output rename_rsp_t rsp
);
   logic        rq_valid;
   rename_req_t rq_data;
   logic        rq_pop;
   logic        cq_valid;
   commit_t     cq_data;
   preg_t       fl_head;
   logic        fl_empty;
   logic        fl_busy;
   logic        fl_pop;
   arch_reg_t   rd_src1;
   arch_reg_t   rd_src2;
   arch_reg_t   rd_dst;
   preg_t       src1_preg;
   preg_t       src2_preg;
   preg_t       old_preg;
   logic        map_wr_en;
   arch_reg_t   map_wr_arch;
   preg_t       map_wr_preg;

   // ========================================
   // inbound queues
   // ========================================
   credit_queue #(.DEPTH(REQ_DEPTH), .payload_t(rename_req_t)) u_req_q (
      .clk, .rst,
      .push(req_valid), .push_data(req), .pop(rq_pop),
      .q_valid(rq_valid), .q_data(rq_data), .credit(req_credit)
   );

   // commits drain one per cycle straight into the free list
   credit_queue #(.DEPTH(CMT_DEPTH), .payload_t(commit_t)) u_cmt_q (
      .clk, .rst,
      .push(cmt_valid), .push_data(cmt), .pop(cq_valid),
      .q_valid(cq_valid), .q_data(cq_data), .credit(cmt_credit)
   );

   // ========================================
   // free list, map table and rename stage
   // ========================================
   preg_free_list u_free_list (
      .clk, .rst,
      .push(cq_valid), .push_preg(cq_data.old_preg), .pop(fl_pop),
      .head_preg(fl_head), .empty(fl_empty), .busy(fl_busy)
   );

   rename_map_table u_map (
      .clk, .rst, .rd_src1, .rd_src2, .rd_dst,
      .wr_en(map_wr_en), .wr_arch(map_wr_arch), .wr_preg(map_wr_preg),
      .src1_preg, .src2_preg, .old_preg
   );

   rename_stage u_stage (
      .clk, .rst,
      .q_valid(rq_valid), .q_data(rq_data), .fl_head, .fl_empty, .fl_busy,
      .src1_preg, .src2_preg, .old_preg,
      .q_pop(rq_pop), .fl_pop, .rd_src1, .rd_src2, .rd_dst,
      .map_wr_en, .map_wr_arch, .map_wr_preg, .rsp_valid, .rsp
   );

endmodule

// ==== dv/renamer_tb.sv ====
`timescale 1ns/1ps
// ========================================
// random rename and commit traffic from a fixed LFSR seed, outputs are
// sampled on the falling edge and compared with an in-order model
// ========================================
module renamer_tb import rename_reg_pkg::*, rename_msg_pkg::*; ();

   localparam int REQ_DEPTH = 4;     // front end credits, equal to the DUT default
   localparam int CMT_DEPTH = 4;     // committer credits
   localparam int NUM_REQ   = 400;   // requests sent, one response each

   logic        clk;
   logic        rst;
   logic        req_valid;
   rename_req_t req;
   logic        req_credit;
   logic        cmt_valid;
   commit_t     cmt;
   logic        cmt_credit;
   logic        rsp_valid;
   rename_rsp_t rsp;

   logic [31:0] lfsr = 32'h195d_85a4;
   int          cyc;          // falling edges since reset release, 1 at the first one
   int          req_sent = 0;
   int          req_back = 0; // req_credit pulses seen
   int          cmt_sent = 0;
   int          cmt_back = 0;
   int          rsp_cnt  = 0;
   bit          cmt_en;       // committer may send

   // ========================================
   // reference model state
   // ========================================
   preg_t       map_m [ARCH_REGS];   // architectural to physical, in response order
   preg_t       free_q [$];          // allocation order, commits appended when sent
   rename_req_t pend_req [$];        // sent and not yet answered
   preg_t       pend_cmt [$];        // old registers waiting to retire

   renamer_top #(.REQ_DEPTH(REQ_DEPTH), .CMT_DEPTH(CMT_DEPTH)) dut0 (
      .clk, .rst, .req_valid, .req, .req_credit,
      .cmt_valid, .cmt, .cmt_credit, .rsp_valid, .rsp
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // taps 32, 22, 2, 1; each returned bit is one LFSR step
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic end_in_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic value_error(input string msg);
      end_in_failure($sformatf("ERR %0t ns: %s", $time, msg));
   endtask

   // true once the oldest open request needs a register that cannot exist
   function automatic bit alloc_stalled();
      return free_q.size() == 0 && pend_req.size() > 0 && pend_req[0].has_dst;
   endfunction

   // ========================================
   // stimulus, one call per rising edge
   // ========================================
   task automatic step();
      rename_req_t r;
      commit_t     c;
      @(posedge clk);
      req_valid <= 1'b0;
      cmt_valid <= 1'b0;
      if (req_sent < NUM_REQ && req_sent - req_back < REQ_DEPTH && rand_bits(2) != 0) begin
         r.src1    = arch_reg_t'(rand_bits(5));
         r.src2    = arch_reg_t'(rand_bits(5));
         r.dst     = arch_reg_t'(rand_bits(5));
         r.has_dst = (rand_bits(2) != 0);   // three in four write a register
         req       <= r;
         req_valid <= 1'b1;
         pend_req.push_back(r);
         req_sent++;
      end
      if (cmt_en && pend_cmt.size() > 0 && cmt_sent - cmt_back < CMT_DEPTH
          && rand_bits(1) != 0) begin
         c.old_preg = pend_cmt.pop_front();   // retire oldest first
         cmt       <= c;
         cmt_valid <= 1'b1;
         free_q.push_back(c.old_preg);        // comes back after everything already free
         cmt_sent++;
      end
   endtask

   task automatic check_response();
      rename_req_t r;
      preg_t       exp_dst;
      assert (pend_req.size() > 0) else value_error("response with no open request");
      r = pend_req.pop_front();
      assert (rsp.src1_preg == map_m[r.src1])
         else value_error($sformatf("src1 got %0d expected %0d", rsp.src1_preg, map_m[r.src1]));
      assert (rsp.src2_preg == map_m[r.src2])
         else value_error($sformatf("src2 got %0d expected %0d", rsp.src2_preg, map_m[r.src2]));
      assert (rsp.has_dst == r.has_dst) else value_error("has_dst differs from the request");
      if (r.has_dst) begin
         assert (free_q.size() > 0) else value_error("allocation with no free register");
         exp_dst = free_q.pop_front();
         assert (rsp.dst_preg == exp_dst)
            else value_error($sformatf("dst got %0d expected %0d", rsp.dst_preg, exp_dst));
         assert (rsp.old_preg == map_m[r.dst])
            else value_error($sformatf("old got %0d expected %0d", rsp.old_preg, map_m[r.dst]));
         pend_cmt.push_back(map_m[r.dst]);
         map_m[r.dst] = exp_dst;   // later requests see the new mapping
      end
      rsp_cnt++;
   endtask

   // outputs settle after the rising edge, so everything is read here
   always @(negedge clk) begin
      if (rst) begin
         cyc = 0;
      end else begin
         cyc++;
         if (req_credit)
            req_back++;
         if (cmt_credit)
            cmt_back++;
         assert (req_back <= req_sent) else value_error("more request credits than requests");
         assert (cmt_back <= cmt_sent) else value_error("more commit credits than commits");
         // the preload takes one edge per register, the first rename one edge more
         assert (!rsp_valid || cyc > PREGS - ARCH_REGS + 1)
            else value_error("response while free list busy");
         if (rsp_valid)
            check_response();
      end
   end

   // ========================================
   // test sequence
   // ========================================
   initial begin
      int n;
      int back0;
      int rsp0;
      rst       = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      cmt_valid = 1'b0;
      cmt       = '0;
      cmt_en    = 1'b0;   // hold commits until the free list runs dry
      for (int i = 0; i < ARCH_REGS; i++)
         map_m[i] = preg_t'(i);
      for (int i = ARCH_REGS; i < PREGS; i++)
         free_q.push_back(preg_t'(i));
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      n = 0;
      while (!alloc_stalled()) begin
         step();
         n++;
         if (n > 2000)
            end_in_failure("timeout: the free list never ran out of registers");
      end
      back0 = req_back;
      rsp0  = rsp_cnt;
      repeat (40) step();   // nothing may drain while no register is free
      assert (req_back == back0 && rsp_cnt == rsp0)
         else value_error("credits or responses arrived with the free list empty");

      cmt_en = 1'b1;
      n = 0;
      while (req_back == back0) begin
         step();
         n++;
         if (n > 300)
            end_in_failure("timeout: request credits did not resume after commits");
      end

      n = 0;
      while (rsp_cnt < NUM_REQ) begin
         step();
         n++;
         if (n > 20000)
            end_in_failure("timeout: not every request got its response");
      end

      n = 0;
      while (pend_cmt.size() > 0 || req_back != req_sent || cmt_back != cmt_sent) begin
         step();
         n++;
         if (n > 1000)
            end_in_failure("timeout: commits or credits did not drain at the end");
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== project.f ====
rtl/rename_reg_pkg.sv
rtl/rename_msg_pkg.sv
rtl/credit_queue.sv
rtl/preg_free_list.sv
rtl/rename_map_table.sv
rtl/rename_stage.sv
rtl/renamer_top.sv
dv/renamer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the renamer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f project.f --top-module renamer_tb -o renamer_sim
./obj_dir/renamer_sim 2>&1 | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
   echo "run_sim: simulation passed"
else
   echo "run_sim: simulation failed, see sim.log"
   exit 1
fi
